// File: design/cpu_defs_pkg.sv
`default_nettype none

package cpu_defs_pkg;

// Bit positions in the stall and flush vectors
typedef enum logic [1:0] {
	MM = 2'd0,
	EX = 2'd1,
	ID = 2'd2,
	IF = 2'd3
} stage_idx_e;

localparam logic [3:0] STALL_ALL    = 4'b1111;
localparam logic [3:0] STALL_FRONT3 = 4'b1110;
localparam logic [3:0] STALL_FRONT2 = 4'b1100;

localparam logic [3:0] FLUSH_ALL    = 4'b1111;
localparam logic [3:0] FLUSH_FRONT2 = 4'b1100;

// MIPS ExcCode values, ERET parked on an unused code
typedef enum logic [4:0] {
	INT  = 5'd0,
	ADEL = 5'd4,
	ADES = 5'd5,
	SYS  = 5'd8,
	BP   = 5'd9,
	RI   = 5'd10,
	OV   = 5'd12,
	ERET = 5'd31
} exc_code_e;

localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;

endpackage

`default_nettype wire

// File: design/fetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer #(
	parameter int FETCH_NUM = 4,
	parameter int ADDR_W    = 32
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              push,
	input  logic [ADDR_W-1:0] push_pc,
	input  logic [31:0]       push_instr,
	input  logic              stall_id,
	input  logic              flush_if,
	output logic              head_valid,
	output logic [ADDR_W-1:0] head_pc,
	output logic [31:0]       head_instr,
	output logic              avail,
	output logic              full
);

localparam int PTR_W = $clog2(FETCH_NUM);
localparam int CNT_W = $clog2(FETCH_NUM + 1);

logic [ADDR_W-1:0] pc_mem    [FETCH_NUM];
logic [31:0]       instr_mem [FETCH_NUM];

logic [PTR_W-1:0] rd_ptr;
logic [PTR_W-1:0] wr_ptr;
logic [CNT_W-1:0] count;
logic             do_push;
logic             do_pop;

// Wraps for depths that are not a power of two
function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
	return (ptr == PTR_W'(FETCH_NUM - 1)) ? '0 : ptr + 1'b1;
endfunction

assign head_valid = (count != '0);
assign avail      = (count != '0); // any entry buffered
assign full       = (count == CNT_W'(FETCH_NUM));

assign do_push = push & ~full & ~flush_if; // push lost on flush
assign do_pop  = head_valid & ~stall_id & ~flush_if;

assign head_pc    = pc_mem[rd_ptr];
assign head_instr = instr_mem[rd_ptr];

always_ff @(posedge clk) begin
	if (rst || flush_if) begin
		rd_ptr <= '0;
		wr_ptr <= '0;
		count  <= '0;
	end else begin
		if (do_push)
			wr_ptr <= ptr_next(wr_ptr);
		if (do_pop)
			rd_ptr <= ptr_next(rd_ptr);
		count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
	end
end

always_ff @(posedge clk) begin
	if (do_push) begin
		pc_mem[wr_ptr]    <= push_pc;
		instr_mem[wr_ptr] <= push_instr;
	end
end

endmodule

`default_nettype wire

// File: design/branch_hold.sv
`timescale 1ns/1ns
`default_nettype none

module branch_hold #(
	parameter int ADDR_W = 32
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              ex_br_valid,
	input  logic              ex_br_mispredict,
	input  logic [ADDR_W-1:0] ex_br_target,
	input  logic              hold,
	input  logic              defer,
	output logic              br_valid,
	output logic              br_mispredict,
	output logic [ADDR_W-1:0] br_target,
	output logic              dly_valid,
	output logic              dly_mispredict,
	output logic [ADDR_W-1:0] dly_target
);

logic              hold_q;
logic              held_valid;
logic              held_mispredict;
logic [ADDR_W-1:0] held_target;

always_ff @(posedge clk) begin
	if (rst)
		hold_q <= 1'b0;
	else
		hold_q <= hold;
end

// Copy follows EX until a hold starts, then stays frozen
always_ff @(posedge clk) begin
	if (!hold_q) begin
		held_valid      <= ex_br_valid;
		held_mispredict <= ex_br_mispredict;
		held_target     <= ex_br_target;
	end
end

assign br_valid      = hold_q ? held_valid      : ex_br_valid;
assign br_mispredict = hold_q ? held_mispredict : ex_br_mispredict;
assign br_target     = hold_q ? held_target     : ex_br_target;

// Delay slot already buffered, replay the mispredict next cycle
always_ff @(posedge clk) begin
	if (rst)
		dly_valid <= 1'b0;
	else
		dly_valid <= defer;
end

always_ff @(posedge clk) begin
	if (defer) begin
		dly_mispredict <= br_mispredict;
		dly_target     <= br_target;
	end
end

endmodule

`default_nettype wire

// File: design/except_unit.sv
`timescale 1ns/1ns
`default_nettype none

module except_unit #(
	parameter int ADDR_W = 32
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   exc_valid,
	input  cpu_defs_pkg::exc_code_e exc_code,
	input  logic [ADDR_W-1:0]      exc_pc,
	input  logic                   exc_in_ds,
	input  logic                   kill,
	output logic                   except_valid,
	output logic                   alpha_taken,
	output logic [ADDR_W-1:0]      exc_target,
	output logic [ADDR_W-1:0]      exc_epc
);

import cpu_defs_pkg::*;

logic is_eret;

assign is_eret = (exc_code == ERET);

// A delayed mispredict flushes MM, so the request dies with it
always_ff @(posedge clk) begin
	if (rst || kill)
		except_valid <= 1'b0;
	else
		except_valid <= exc_valid;
end

always_ff @(posedge clk) begin
	if (rst)
		alpha_taken <= 1'b0;
	else if (exc_valid)
		alpha_taken <= ~is_eret; // ERET keeps EX and MM
end

always_ff @(posedge clk) begin
	if (exc_valid) begin
		exc_target <= is_eret ? exc_pc : ADDR_W'(EXC_VECTOR);
		// Branch in front of the slot restarts
		exc_epc    <= exc_in_ds ? exc_pc - ADDR_W'(4) : exc_pc;
	end
end

endmodule

`default_nettype wire

// File: design/ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl #(
	parameter int ADDR_W = 32
) (
	input  logic              rst,
	input  logic              stall_from_id,
	input  logic              stall_from_ex,
	input  logic              stall_from_mm,
	input  logic              br_valid,
	input  logic              br_mispredict,
	input  logic [ADDR_W-1:0] br_target,
	input  logic              ex_ds_valid,
	input  logic              dly_valid,
	input  logic              dly_mispredict,
	input  logic [ADDR_W-1:0] dly_target,
	input  logic              except_valid,
	input  logic              alpha_taken,
	input  logic [ADDR_W-1:0] exc_target,
	input  logic              fetch_avail,
	output logic              stall_if,
	output logic              stall_id,
	output logic              stall_ex,
	output logic              stall_mm,
	output logic              flush_if,
	output logic              flush_id,
	output logic              flush_ex,
	output logic              flush_mm,
	output logic              flush_delayed_mispredict,
	output logic              hold_resolved_branch,
	output logic              delayslot_not_exec,
	output logic              defer,
	output logic              redirect_valid,
	output logic [ADDR_W-1:0] redirect_pc
);

import cpu_defs_pkg::*;

logic [3:0] stall;
logic [3:0] flush;
logic       mispredict;
logic       mispredict_with_delayslot;
logic       wait_delayslot;
logic       flush_mispredict;
logic       resolved_valid;

assign stall_if = stall[IF];
assign stall_id = stall[ID];
assign stall_ex = stall[EX];
assign stall_mm = stall[MM];
assign flush_if = flush[IF];
assign flush_id = flush[ID];
assign flush_ex = flush[EX];
assign flush_mm = flush[MM];

assign mispredict                = br_valid & br_mispredict;
assign flush_delayed_mispredict  = dly_valid & dly_mispredict;
assign delayslot_not_exec        = br_valid & ~ex_ds_valid;
assign wait_delayslot            = delayslot_not_exec & ~fetch_avail; // slot not fetched yet
assign mispredict_with_delayslot = mispredict & ex_ds_valid;
assign defer                     = mispredict & delayslot_not_exec & fetch_avail;

// Branch and slot must leave EX together, and not under a multi-cycle op
assign flush_mispredict = mispredict
	& ~delayslot_not_exec
	& ~stall_from_ex
	& ~(mispredict_with_delayslot & stall_ex);

assign hold_resolved_branch = mispredict & (stall_ex | stall_mm) & ~flush_id;
assign resolved_valid       = br_valid & ~wait_delayslot;

always_comb begin
	if (flush_delayed_mispredict)
		flush = FLUSH_ALL;
	else if (except_valid)
		flush = {2'b11, {2{alpha_taken}}};
	else if (flush_mispredict)
		flush = FLUSH_FRONT2;
	else
		flush = '0;
end

always_comb begin
	if (rst || stall_from_mm)
		stall = STALL_ALL;
	else if (stall_from_ex || wait_delayslot)
		stall = STALL_FRONT3;
	else if (stall_from_id)
		stall = STALL_FRONT2;
	else
		stall = '0;
end

always_comb begin
	redirect_valid = 1'b0;
	redirect_pc    = br_target;
	if (flush_delayed_mispredict) begin
		redirect_valid = 1'b1;
		redirect_pc    = dly_target;
	end else if (except_valid) begin
		redirect_valid = 1'b1;
		redirect_pc    = exc_target;
	end else if (resolved_valid && flush_mispredict) begin
		redirect_valid = 1'b1;
	end
end

endmodule

`default_nettype wire

// File: design/pipe_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_top #(
	parameter int FETCH_NUM = 4,
	parameter int ADDR_W    = 32
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    fetch_push,
	input  logic [ADDR_W-1:0]       fetch_pc,
	input  logic [31:0]             fetch_instr,
	input  logic                    stall_from_id,
	input  logic                    stall_from_ex,
	input  logic                    stall_from_mm,
	input  logic                    ex_br_valid,
	input  logic                    ex_br_mispredict,
	input  logic [ADDR_W-1:0]       ex_br_target,
	input  logic                    ex_ds_valid,
	input  logic                    exc_valid,
	input  cpu_defs_pkg::exc_code_e exc_code,
	input  logic [ADDR_W-1:0]       exc_pc,
	input  logic                    exc_in_ds,
	output logic                    stall_if,
	output logic                    stall_id,
	output logic                    stall_ex,
	output logic                    stall_mm,
	output logic                    flush_if,
	output logic                    flush_id,
	output logic                    flush_ex,
	output logic                    flush_mm,
	output logic                    id_valid,
	output logic [ADDR_W-1:0]       id_pc,
	output logic [31:0]             id_instr,
	output logic                    fetch_full,
	output logic                    redirect_valid,
	output logic [ADDR_W-1:0]       redirect_pc,
	output logic                    hold_resolved_branch,
	output logic                    delayslot_not_exec,
	output logic [ADDR_W-1:0]       exc_epc
);

logic              fetch_avail;
logic              br_valid;
logic              br_mispredict;
logic [ADDR_W-1:0] br_target;
logic              dly_valid;
logic              dly_mispredict;
logic [ADDR_W-1:0] dly_target;
logic              defer;
logic              except_valid;
logic              alpha_taken;
logic [ADDR_W-1:0] exc_target;
logic              flush_delayed_mispredict;

fetch_buffer #(
	.FETCH_NUM(FETCH_NUM),
	.ADDR_W   (ADDR_W)
) u_fetch_buffer (
	.clk       (clk),
	.rst       (rst),
	.push      (fetch_push),
	.push_pc   (fetch_pc),
	.push_instr(fetch_instr),
	.stall_id  (stall_id),
	.flush_if  (flush_if),
	.head_valid(id_valid),
	.head_pc   (id_pc),
	.head_instr(id_instr),
	.avail     (fetch_avail),
	.full      (fetch_full)
);

branch_hold #(
	.ADDR_W(ADDR_W)
) u_branch_hold (
	.clk             (clk),
	.rst             (rst),
	.ex_br_valid     (ex_br_valid),
	.ex_br_mispredict(ex_br_mispredict),
	.ex_br_target    (ex_br_target),
	.hold            (hold_resolved_branch),
	.defer           (defer),
	.br_valid        (br_valid),
	.br_mispredict   (br_mispredict),
	.br_target       (br_target),
	.dly_valid       (dly_valid),
	.dly_mispredict  (dly_mispredict),
	.dly_target      (dly_target)
);

except_unit #(
	.ADDR_W(ADDR_W)
) u_except_unit (
	.clk         (clk),
	.rst         (rst),
	.exc_valid   (exc_valid),
	.exc_code    (exc_code),
	.exc_pc      (exc_pc),
	.exc_in_ds   (exc_in_ds),
	.kill        (flush_delayed_mispredict),
	.except_valid(except_valid),
	.alpha_taken (alpha_taken),
	.exc_target  (exc_target),
	.exc_epc     (exc_epc)
);

ctrl #(
	.ADDR_W(ADDR_W)
) u_ctrl (
	.rst                     (rst),
	.stall_from_id           (stall_from_id),
	.stall_from_ex           (stall_from_ex),
	.stall_from_mm           (stall_from_mm),
	.br_valid                (br_valid),
	.br_mispredict           (br_mispredict),
	.br_target               (br_target),
	.ex_ds_valid             (ex_ds_valid),
	.dly_valid               (dly_valid),
	.dly_mispredict          (dly_mispredict),
	.dly_target              (dly_target),
	.except_valid            (except_valid),
	.alpha_taken             (alpha_taken),
	.exc_target              (exc_target),
	.fetch_avail             (fetch_avail),
	.stall_if                (stall_if),
	.stall_id                (stall_id),
	.stall_ex                (stall_ex),
	.stall_mm                (stall_mm),
	.flush_if                (flush_if),
	.flush_id                (flush_id),
	.flush_ex                (flush_ex),
	.flush_mm                (flush_mm),
	.flush_delayed_mispredict(flush_delayed_mispredict),
	.hold_resolved_branch    (hold_resolved_branch),
	.delayslot_not_exec      (delayslot_not_exec),
	.defer                   (defer),
	.redirect_valid          (redirect_valid),
	.redirect_pc             (redirect_pc)
);

endmodule

`default_nettype wire

// File: testbench/pipe_ctrl_properties.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_properties (
	input logic clk,
	input logic rst,
	input logic fetch_push,
	input logic fetch_full,
	input logic flush_if,
	input logic flush_id,
	input logic flush_ex,
	input logic flush_mm,
	input logic redirect_valid
);

int         fail_count = 0;
logic [1:0] warm       = 2'b00; // Outputs unknown before the first reset edge

always @(posedge clk)
	warm <= {warm[0], 1'b1};

no_flush_in_reset: assert property (@(posedge clk) disable iff (!warm[1])
	rst |-> !(flush_if | flush_id | flush_ex | flush_mm))
	else begin
		$error("flush raised while reset is high");
		fail_count++;
	end

mm_flush_covers_if: assert property (@(posedge clk) disable iff (!warm[1])
	flush_mm |-> flush_if)
	else begin
		$error("flush_mm without flush_if");
		fail_count++;
	end

redirect_needs_flush: assert property (@(posedge clk) disable iff (!warm[1])
	redirect_valid |-> (flush_if | flush_id | flush_ex | flush_mm))
	else begin
		$error("redirect without any flush");
		fail_count++;
	end

no_push_when_full: assert property (@(posedge clk) disable iff (!warm[1])
	fetch_push |-> !fetch_full)
	else begin
		$error("push into a full fetch buffer");
		fail_count++;
	end

endmodule

bind pipe_ctrl_top pipe_ctrl_properties props_i (
	.clk           (clk),
	.rst           (rst),
	.fetch_push    (fetch_push),
	.fetch_full    (fetch_full),
	.flush_if      (flush_if),
	.flush_id      (flush_id),
	.flush_ex      (flush_ex),
	.flush_mm      (flush_mm),
	.redirect_valid(redirect_valid)
);

`default_nettype wire

// File: testbench/pipe_ctrl_checker.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_checker (
	input  logic        clk,
	input  logic [3:0]  stall,
	input  logic [3:0]  flush,
	input  logic        redirect_valid,
	input  logic [31:0] redirect_pc,
	input  logic        hold_resolved_branch,
	input  logic        delayslot_not_exec,
	input  logic        id_valid,
	input  logic [31:0] id_pc,
	input  logic [31:0] id_instr,
	input  logic        fetch_full,
	input  logic [31:0] exc_epc,
	input  logic [3:0]  exp_stall,
	input  logic [3:0]  exp_flush,
	input  logic        exp_redirect_valid,
	input  logic [31:0] exp_redirect_pc,
	input  logic        exp_hold,
	input  logic        exp_dsne,
	input  logic        exp_id_valid,
	input  logic [31:0] exp_id_pc,
	input  logic [31:0] exp_id_instr,
	input  logic        exp_full,
	input  logic [31:0] exp_epc,
	input  logic        exp_epc_known,
	output int          errors,
	output int          checks
);

int err_count = 0;
int chk_count = 0;

assign errors = err_count;
assign checks = chk_count;

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
	chk_count++;
	if (got !== want) begin
		err_count++;
		$display("[FAIL] %0t %s: got %h expected %h", $time, name, got, want);
	end
endtask

// Mid-cycle, inputs settled since posedge + 1
always @(negedge clk) begin
	check_value("stall_if_id_ex_mm", 32'(stall), 32'(exp_stall));
	check_value("flush_if_id_ex_mm", 32'(flush), 32'(exp_flush));
	check_value("redirect_valid", 32'(redirect_valid), 32'(exp_redirect_valid));
	if (exp_redirect_valid)
		check_value("redirect_pc", redirect_pc, exp_redirect_pc);
	check_value("hold_resolved_branch", 32'(hold_resolved_branch), 32'(exp_hold));
	check_value("delayslot_not_exec", 32'(delayslot_not_exec), 32'(exp_dsne));
	check_value("id_valid", 32'(id_valid), 32'(exp_id_valid));
	if (exp_id_valid) begin
		check_value("id_pc", id_pc, exp_id_pc);
		check_value("id_instr", id_instr, exp_id_instr);
	end
	check_value("fetch_full", 32'(fetch_full), 32'(exp_full));
	if (exp_epc_known)
		check_value("exc_epc", exc_epc, exp_epc);
end

endmodule

`default_nettype wire

// File: testbench/tb_pipe_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_ctrl;

import cpu_defs_pkg::*;

localparam int FETCH_NUM   = 4;
localparam int CYCLE_LIMIT = 2000; // About 470 stimulus cycles plus margin

logic        clk = 1'b0;
logic        rst;
logic        fetch_push;
logic [31:0] fetch_pc;
logic [31:0] fetch_instr;
logic        stall_from_id;
logic        stall_from_ex;
logic        stall_from_mm;
logic        ex_br_valid;
logic        ex_br_mispredict;
logic [31:0] ex_br_target;
logic        ex_ds_valid;
logic        exc_valid;
exc_code_e   exc_code;
logic [31:0] exc_pc;
logic        exc_in_ds;
logic        stall_if;
logic        stall_id;
logic        stall_ex;
logic        stall_mm;
logic        flush_if;
logic        flush_id;
logic        flush_ex;
logic        flush_mm;
logic        id_valid;
logic [31:0] id_pc;
logic [31:0] id_instr;
logic        fetch_full;
logic        redirect_valid;
logic [31:0] redirect_pc;
logic        hold_resolved_branch;
logic        delayslot_not_exec;
logic [31:0] exc_epc;

// Expected values
logic [3:0]  exp_stall;
logic [3:0]  exp_flush;
logic        exp_redirect_valid;
logic [31:0] exp_redirect_pc;
logic        exp_hold;
logic        exp_dsne;
logic        exp_defer;
logic        exp_fdm;
logic        exp_id_valid;
logic [31:0] exp_id_pc;
logic [31:0] exp_id_instr;
logic        exp_full;

// Model state
logic [31:0] fifo_pc[$];
logic [31:0] fifo_instr[$];
logic        m_hold_q;
logic        m_held_valid;
logic        m_held_mis;
logic [31:0] m_held_target;
logic        m_dly_valid;
logic        m_dly_mis;
logic [31:0] m_dly_target;
logic        m_exc_valid;
logic        m_alpha;
logic [31:0] m_exc_target;
logic [31:0] m_epc;
logic        m_epc_known = 1'b0;

integer      seed;
int          cycles = 0;
int          errors;
int          checks;
exc_code_e   codes [8] = '{INT, ADEL, ADES, SYS, BP, RI, OV, ERET};

pipe_ctrl_top #(
	.FETCH_NUM(FETCH_NUM),
	.ADDR_W   (32)
) dut_i (.*);

pipe_ctrl_checker checker_i (
	.clk                 (clk),
	.stall               ({stall_if, stall_id, stall_ex, stall_mm}),
	.flush               ({flush_if, flush_id, flush_ex, flush_mm}),
	.redirect_valid      (redirect_valid),
	.redirect_pc         (redirect_pc),
	.hold_resolved_branch(hold_resolved_branch),
	.delayslot_not_exec  (delayslot_not_exec),
	.id_valid            (id_valid),
	.id_pc               (id_pc),
	.id_instr            (id_instr),
	.fetch_full          (fetch_full),
	.exc_epc             (exc_epc),
	.exp_stall           (exp_stall),
	.exp_flush           (exp_flush),
	.exp_redirect_valid  (exp_redirect_valid),
	.exp_redirect_pc     (exp_redirect_pc),
	.exp_hold            (exp_hold),
	.exp_dsne            (exp_dsne),
	.exp_id_valid        (exp_id_valid),
	.exp_id_pc           (exp_id_pc),
	.exp_id_instr        (exp_id_instr),
	.exp_full            (exp_full),
	.exp_epc             (m_epc),
	.exp_epc_known       (m_epc_known),
	.errors              (errors),
	.checks              (checks)
);

initial begin
	forever #2 clk = ~clk;
end

// {stall, flush, redirect_valid, redirect_pc, hold, dsne, defer, delayed flush}
function automatic logic [44:0] ref_ctrl();
	logic        bv;
	logic        bm;
	logic [31:0] bt;
	logic        avail;
	logic        mis;
	logic        dsne;
	logic        wait_ds;
	logic        fdm;
	logic        fmis;
	logic [3:0]  st;
	logic [3:0]  fl;
	logic        rv;
	logic [31:0] rpc;
	bv      = m_hold_q ? m_held_valid : ex_br_valid;
	bm      = m_hold_q ? m_held_mis : ex_br_mispredict;
	bt      = m_hold_q ? m_held_target : ex_br_target;
	avail   = (fifo_pc.size() != 0);
	mis     = bv & bm;
	dsne    = bv & ~ex_ds_valid;
	wait_ds = dsne & ~avail;
	fdm     = m_dly_valid & m_dly_mis;
	if (rst || stall_from_mm)
		st = STALL_ALL;
	else if (stall_from_ex || wait_ds)
		st = STALL_FRONT3;
	else if (stall_from_id)
		st = STALL_FRONT2;
	else
		st = 4'b0000;
	fmis = mis & ex_ds_valid & ~stall_from_ex & ~st[EX]; // branch and slot leave EX together
	if (fdm)
		fl = FLUSH_ALL;
	else if (m_exc_valid)
		fl = m_alpha ? FLUSH_ALL : FLUSH_FRONT2;
	else if (fmis)
		fl = FLUSH_FRONT2;
	else
		fl = 4'b0000;
	rv  = 1'b1;
	rpc = bt;
	if (fdm)
		rpc = m_dly_target;
	else if (m_exc_valid)
		rpc = m_exc_target;
	else
		rv = fmis & ~wait_ds;
	return {st, fl, rv, rpc, mis & (st[EX] | st[MM]) & ~fl[ID], dsne, mis & dsne & avail, fdm};
endfunction

task automatic predict();
	{exp_stall, exp_flush, exp_redirect_valid, exp_redirect_pc,
		exp_hold, exp_dsne, exp_defer, exp_fdm} = ref_ctrl();
	exp_id_valid = (fifo_pc.size() != 0);
	exp_id_pc    = 32'h0;
	exp_id_instr = 32'h0;
	if (exp_id_valid) begin
		exp_id_pc    = fifo_pc[0];
		exp_id_instr = fifo_instr[0];
	end
	exp_full = (fifo_pc.size() == FETCH_NUM);
endtask

// Model registers advance on the same edge as the DUT
always @(posedge clk) begin
	logic        push_ok;
	logic        pop_ok;
	logic        br_m;
	logic [31:0] br_t;
	push_ok = fetch_push && (fifo_pc.size() < FETCH_NUM);
	pop_ok  = (fifo_pc.size() != 0) && !exp_stall[ID];
	br_m    = m_hold_q ? m_held_mis : ex_br_mispredict;
	br_t    = m_hold_q ? m_held_target : ex_br_target;
	if (rst || exp_flush[IF]) begin
		fifo_pc.delete();
		fifo_instr.delete();
	end else begin
		if (pop_ok) begin
			void'(fifo_pc.pop_front());
			void'(fifo_instr.pop_front());
		end
		if (push_ok) begin
			fifo_pc.push_back(fetch_pc);
			fifo_instr.push_back(fetch_instr);
		end
	end
	m_hold_q <= rst ? 1'b0 : exp_hold;
	if (!m_hold_q) begin
		m_held_valid  <= ex_br_valid;
		m_held_mis    <= ex_br_mispredict;
		m_held_target <= ex_br_target;
	end
	m_dly_valid <= rst ? 1'b0 : exp_defer;
	if (exp_defer) begin
		m_dly_mis    <= br_m;
		m_dly_target <= br_t;
	end
	m_exc_valid <= (rst || exp_fdm) ? 1'b0 : exc_valid;
	if (rst)
		m_alpha <= 1'b0;
	else if (exc_valid)
		m_alpha <= (exc_code != ERET);
	if (exc_valid) begin
		m_exc_target <= (exc_code == ERET) ? exc_pc : EXC_VECTOR;
		m_epc        <= exc_in_ds ? exc_pc - 32'd4 : exc_pc;
		m_epc_known  <= 1'b1;
	end
end

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles >= CYCLE_LIMIT) begin
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test failures found");
		$finish;
	end
end

task automatic tick();
	predict();
	@(posedge clk);
	#1;
endtask

task automatic idle();
	fetch_push       = 1'b0;
	fetch_pc         = 32'h0;
	fetch_instr      = 32'h0;
	stall_from_id    = 1'b0;
	stall_from_ex    = 1'b0;
	stall_from_mm    = 1'b0;
	ex_br_valid      = 1'b0;
	ex_br_mispredict = 1'b0;
	ex_br_target     = 32'h0;
	ex_ds_valid      = 1'b0;
	exc_valid        = 1'b0;
	exc_code         = INT;
	exc_pc           = 32'h0;
	exc_in_ds        = 1'b0;
endtask

task automatic drive_stalls(input logic id, input logic ex, input logic mm);
	stall_from_id = id;
	stall_from_ex = ex;
	stall_from_mm = mm;
	tick();
endtask

task automatic drive_branch(input logic v, input logic mis, input logic ds, input logic [31:0] t);
	ex_br_valid      = v;
	ex_br_mispredict = mis;
	ex_ds_valid      = ds;
	ex_br_target     = t;
	tick();
endtask

task automatic push_entry(input logic [31:0] pc, input logic [31:0] instr);
	fetch_push  = 1'b1;
	fetch_pc    = pc;
	fetch_instr = instr;
	tick();
	fetch_push  = 1'b0;
endtask

task automatic raise_exception(input exc_code_e code, input logic [31:0] pc, input logic in_ds);
	exc_valid = 1'b1;
	exc_code  = code;
	exc_pc    = pc;
	exc_in_ds = in_ds;
	tick();
	exc_valid = 1'b0;
	tick(); // request lands here
	tick();
endtask

task automatic random_cycle();
	logic [31:0] r;
	r = $random(seed);
	stall_from_id    = (r[2:0] == 3'd0);
	stall_from_ex    = (r[5:3] == 3'd0);
	stall_from_mm    = (r[9:6] == 4'd0);
	ex_br_valid      = (r[11:10] == 2'd0);
	ex_br_mispredict = r[12];
	ex_ds_valid      = r[13] | r[14];
	exc_valid        = (r[18:15] == 4'd0);
	exc_code         = codes[r[21:19]];
	exc_in_ds        = r[22];
	fetch_push       = r[23] && (fifo_pc.size() < FETCH_NUM);
	ex_br_target     = $random(seed) & 32'hffff_fffc;
	exc_pc           = $random(seed) & 32'hffff_fffc;
	fetch_pc         = $random(seed) & 32'hffff_fffc;
	fetch_instr      = $random(seed);
	tick();
endtask

initial begin
	int prop_errors;
	seed = 32'hb18bbdf3;
	rst  = 1'b1;
	idle();
	repeat (10) tick();
	rst = 1'b0;
	tick();

	drive_stalls(1'b1, 1'b0, 1'b0);
	drive_stalls(1'b0, 1'b1, 1'b0);
	drive_stalls(1'b0, 1'b0, 1'b1);
	drive_stalls(1'b1, 1'b1, 1'b1); // MM wins
	drive_stalls(1'b0, 1'b0, 1'b0);

	drive_branch(1'b1, 1'b1, 1'b1, 32'h1000_0040);
	drive_branch(1'b0, 1'b0, 1'b0, 32'h0);
	stall_from_ex = 1'b1;
	drive_branch(1'b1, 1'b1, 1'b1, 32'h1000_0080);
	drive_branch(1'b0, 1'b0, 1'b1, 32'h0); // held copy replays
	drive_branch(1'b0, 1'b0, 1'b1, 32'h0);
	stall_from_ex = 1'b0;
	drive_branch(1'b0, 1'b0, 1'b1, 32'h0);
	drive_branch(1'b0, 1'b0, 1'b0, 32'h0);

	// Slot not fetched yet, then arrives
	drive_branch(1'b1, 1'b1, 1'b0, 32'h1000_0100);
	fetch_push = 1'b1;
	fetch_pc   = 32'h0040_0010;
	drive_branch(1'b1, 1'b1, 1'b0, 32'h1000_0100);
	fetch_push = 1'b0;
	drive_branch(1'b1, 1'b1, 1'b0, 32'h1000_0100);
	drive_branch(1'b0, 1'b0, 1'b0, 32'h0);
	push_entry(32'h0040_0020, 32'h2408_0001);
	drive_branch(1'b1, 1'b1, 1'b0, 32'h1000_0200);
	drive_branch(1'b0, 1'b0, 1'b0, 32'h0);
	tick();

	raise_exception(SYS, 32'h8000_0100, 1'b0);
	raise_exception(ADEL, 32'h8000_0204, 1'b1);
	raise_exception(ERET, 32'h8000_0300, 1'b0);

	stall_from_id = 1'b1;
	push_entry(32'h0040_0100, 32'h2400_00a0);
	push_entry(32'h0040_0104, 32'h2400_00a1);
	tick();
	stall_from_id = 1'b0;
	repeat (3) tick();
	stall_from_id = 1'b1;
	for (int i = 0; i < FETCH_NUM; i++)
		push_entry(32'h0040_0200 + 32'(i * 4), 32'h2400_0000 + 32'(i));
	repeat (2) tick();
	stall_from_id = 1'b0;
	repeat (2) tick();
	stall_from_id = 1'b1;
	push_entry(32'h0040_0300, 32'h2400_00b0);
	push_entry(32'h0040_0304, 32'h2400_00b1);
	raise_exception(BP, 32'h8000_0400, 1'b0); // Flush empties the buffer
	stall_from_id = 1'b0;
	tick();

	repeat (400) random_cycle();
	idle();
	repeat (5) tick();

	prop_errors = dut_i.props_i.fail_count;
	$display("Checks: %0d, compare errors: %0d, assertion errors: %0d",
		checks, errors, prop_errors);
	if (errors == 0 && prop_errors == 0)
		$display("All tests passed!");
	else
		$display("Test failures found");
	$finish;
end

endmodule

`default_nettype wire

// File: pipe_ctrl.f
design/cpu_defs_pkg.sv
design/fetch_buffer.sv
design/branch_hold.sv
design/except_unit.sv
design/ctrl.sv
design/pipe_ctrl_top.sv
testbench/pipe_ctrl_properties.sv
testbench/pipe_ctrl_checker.sv
testbench/tb_pipe_ctrl.sv

// File: Makefile
TOP = tb_pipe_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f pipe_ctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f pipe_ctrl.f --top-module $(TOP) \
		-o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
